/* logic/rv_isa_pkg.sv */
// RV32I encoding types and opcode/funct constants, imported by the decode and execute logic.
`default_nettype none

package rv_isa_pkg;

    // ########################################################################
    // encoding field types
    // ########################################################################

    typedef logic [31:0] xlen_word_t;
    typedef logic [31:0] instr_word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;

    localparam int NUM_REGS = 32;

    // ########################################################################
    // opcodes
    // ########################################################################

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 values shared by OP and OP-IMM.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // alt selects SUB and SRA.
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

/* logic/exec_ctrl_pkg.sv */
// Internal control of the execution unit: ALU operation codes and the structs passed between stages.
`default_nettype none

package exec_ctrl_pkg;

    // ########################################################################
    // alu operation codes
    // ########################################################################

    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_XOR  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_SLL  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_SLT  = 4'd8;
    localparam alu_op_t ALU_SLTU = 4'd9;
    // forwards operand b, used by lui.
    localparam alu_op_t ALU_PASS = 4'd10;

    // ########################################################################
    // stage structs
    // ########################################################################

    typedef struct packed {
        logic                   valid;
        alu_op_t                alu_op;
        logic                   use_imm;
        rv_isa_pkg::reg_addr_t  rs1;
        rv_isa_pkg::reg_addr_t  rs2;
        rv_isa_pkg::reg_addr_t  rd;
        rv_isa_pkg::xlen_word_t imm;
    } decoded_instr_t;

    typedef struct packed {
        logic                   valid;
        rv_isa_pkg::reg_addr_t  rd;
        rv_isa_pkg::xlen_word_t value;
    } exec_result_t;

endpackage

`default_nettype wire

/* logic/instr_decoder.sv */
// Decode stage: classifies an RV32I instruction, builds its immediate and registers the result.
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          instr_valid_i,
    input  rv_isa_pkg::instr_word_t       instr_i,
    output exec_ctrl_pkg::decoded_instr_t decoded_o,
    output logic                          illegal_o
);
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    logic           legal_d;
    logic           illegal_q;
    decoded_instr_t dec_d;

    function automatic alu_op_t op_from_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SR:      return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        dec_d     = '0;
        legal_d   = 1'b1;
        dec_d.rs1 = instr_i[19:15];
        dec_d.rs2 = instr_i[24:20];
        dec_d.rd  = instr_i[11:7];
        case (opcode)
            OPC_OP: begin
                dec_d.alu_op = op_from_f3(funct3, funct7 == F7_ALT);
                if (funct7 == F7_ALT) begin
                    legal_d = (funct3 == F3_ADD_SUB) || (funct3 == F3_SR);
                end else begin
                    legal_d = (funct7 == F7_BASE);
                end
            end
            OPC_OP_IMM: begin
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
                dec_d.alu_op  = op_from_f3(funct3, (funct3 == F3_SR) && (funct7 == F7_ALT));
                // shift forms carry shamt and funct7 in the immediate field.
                if ((funct3 == F3_SLL) || (funct3 == F3_SR)) begin
                    dec_d.imm = {27'b0, instr_i[24:20]};
                    legal_d   = (funct7 == F7_BASE) || ((funct3 == F3_SR) && (funct7 == F7_ALT));
                end
            end
            OPC_LUI: begin
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {instr_i[31:12], 12'b0};
                dec_d.alu_op  = ALU_PASS;
            end
            default: begin
                legal_d = 1'b0;
            end
        endcase
        dec_d.valid = instr_valid_i && legal_d;
    end

    // illegal goes through a second flop so it lines up with the result stage.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            decoded_o <= '0;
            illegal_q <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            decoded_o <= dec_d;
            illegal_q <= instr_valid_i && !legal_d;
            illegal_o <= illegal_q;
        end
    end

endmodule

`default_nettype wire

/* logic/carry_lookahead_toplayici.sv */
// 32-bit adder from eight 4-bit carry-lookahead groups, used by the ALU for add and subtract.
`timescale 1ns/1ps
`default_nettype none

module carry_lookahead_toplayici (
    input  rv_isa_pkg::xlen_word_t deger1_i,
    input  rv_isa_pkg::xlen_word_t deger2_i,
    input  logic                   elde_i,
    output rv_isa_pkg::xlen_word_t sonuc_o
);
    logic [31:0] yay;
    logic [31:0] uret;
    logic [31:0] bit_elde;
    logic [6:0]  grup_yay;
    logic [6:0]  grup_uret;
    logic [7:0]  grup_elde;

    assign yay          = deger1_i ^ deger2_i;
    assign uret         = deger1_i & deger2_i;
    assign grup_elde[0] = elde_i;

    // group propagate/generate and the carry chain between groups.
    for (genvar g = 0; g < 7; g++) begin : gen_grup_pg
        assign grup_yay[g]  = &yay[4*g+3:4*g];
        assign grup_uret[g] = uret[4*g+3]
                            | (yay[4*g+3] & uret[4*g+2])
                            | (yay[4*g+3] & yay[4*g+2] & uret[4*g+1])
                            | (yay[4*g+3] & yay[4*g+2] & yay[4*g+1] & uret[4*g]);
        assign grup_elde[g+1] = grup_uret[g] | (grup_yay[g] & grup_elde[g]);
    end

    // lookahead carries inside each group.
    for (genvar g = 0; g < 8; g++) begin : gen_grup_elde
        assign bit_elde[4*g]   = grup_elde[g];
        assign bit_elde[4*g+1] = uret[4*g] | (yay[4*g] & grup_elde[g]);
        assign bit_elde[4*g+2] = uret[4*g+1] | (yay[4*g+1] & uret[4*g])
                               | (yay[4*g+1] & yay[4*g] & grup_elde[g]);
        assign bit_elde[4*g+3] = uret[4*g+2] | (yay[4*g+2] & uret[4*g+1])
                               | (yay[4*g+2] & yay[4*g+1] & uret[4*g])
                               | (yay[4*g+2] & yay[4*g+1] & yay[4*g] & grup_elde[g]);
    end

    assign sonuc_o = yay ^ bit_elde;

endmodule

`default_nettype wire

/* logic/aritmetik_mantik_birimi.sv */
// Execute stage: selects the operands and computes the ALU result combinationally.
`timescale 1ns/1ps
`default_nettype none

module aritmetik_mantik_birimi (
    input  exec_ctrl_pkg::decoded_instr_t decoded_i,
    input  rv_isa_pkg::xlen_word_t        rs1_data_i,
    input  rv_isa_pkg::xlen_word_t        rs2_data_i,
    output exec_ctrl_pkg::exec_result_t   result_o
);
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;

    xlen_word_t deger2;
    xlen_word_t deger2_cla;
    xlen_word_t sonuc_cla;
    xlen_word_t sonuc;
    shamt_t     kaydirma;
    logic       elde_cla;

    assign deger2   = decoded_i.use_imm ? decoded_i.imm : rs2_data_i;
    assign kaydirma = deger2[4:0];

    // subtraction is a + ~b + 1.
    assign elde_cla   = (decoded_i.alu_op == ALU_SUB);
    assign deger2_cla = elde_cla ? ~deger2 : deger2;

    carry_lookahead_toplayici cla (
        .deger1_i (rs1_data_i),
        .deger2_i (deger2_cla),
        .elde_i   (elde_cla),
        .sonuc_o  (sonuc_cla)
    );

    always_comb begin
        case (decoded_i.alu_op)
            ALU_ADD,
            ALU_SUB:  sonuc = sonuc_cla;
            ALU_XOR:  sonuc = rs1_data_i ^ deger2;
            ALU_OR:   sonuc = rs1_data_i | deger2;
            ALU_AND:  sonuc = rs1_data_i & deger2;
            ALU_SLL:  sonuc = rs1_data_i << kaydirma;
            ALU_SRL:  sonuc = rs1_data_i >> kaydirma;
            ALU_SRA:  sonuc = xlen_word_t'($signed(rs1_data_i) >>> kaydirma);
            ALU_SLT:  sonuc = {31'b0, $signed(rs1_data_i) < $signed(deger2)};
            ALU_SLTU: sonuc = {31'b0, rs1_data_i < deger2};
            ALU_PASS: sonuc = deger2;
            default:  sonuc = '0;
        endcase
    end

    assign result_o.valid = decoded_i.valid;
    assign result_o.rd    = decoded_i.rd;
    assign result_o.value = sonuc;

endmodule

`default_nettype wire

/* logic/register_file_writeback.sv */
// Result stage: registers the ALU result, writes it to the register file and serves two read ports.
`timescale 1ns/1ps
`default_nettype none

module register_file_writeback (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  rv_isa_pkg::reg_addr_t       rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t       rs2_addr_i,
    input  exec_ctrl_pkg::exec_result_t exec_i,
    output rv_isa_pkg::xlen_word_t      rs1_data_o,
    output rv_isa_pkg::xlen_word_t      rs2_data_o,
    output logic                        result_valid_o,
    output rv_isa_pkg::reg_addr_t       result_rd_o,
    output rv_isa_pkg::xlen_word_t      result_o
);
    import rv_isa_pkg::*;

    xlen_word_t regs [NUM_REGS];
    logic       wr_en;

    // x0 is hardwired, never written.
    assign wr_en = exec_i.valid && (exec_i.rd != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            result_valid_o <= 1'b0;
        end else begin
            if (wr_en) begin
                regs[exec_i.rd] <= exec_i.value;
            end
            result_valid_o <= exec_i.valid;
        end
    end

    // payload of the output triple.
    always_ff @(posedge clk_i) begin
        result_rd_o <= exec_i.rd;
        result_o    <= exec_i.value;
    end

    // write and result share an edge, so no bypass is needed.
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

/* logic/integer_exec_unit.sv */
// Top level of the RV32I integer execution unit; connects decode, execute and result stages.
`timescale 1ns/1ps
`default_nettype none

module integer_exec_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    instr_valid_i,
    input  rv_isa_pkg::instr_word_t instr_i,
    output logic                    result_valid_o,
    output rv_isa_pkg::reg_addr_t   result_rd_o,
    output rv_isa_pkg::xlen_word_t  result_o,
    output logic                    illegal_o
);
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;

    decoded_instr_t decoded;
    exec_result_t   exec_res;
    xlen_word_t     rs1_data;
    xlen_word_t     rs2_data;

    instr_decoder u_decoder (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .decoded_o     (decoded),
        .illegal_o     (illegal_o)
    );

    aritmetik_mantik_birimi u_alu (
        .decoded_i  (decoded),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .result_o   (exec_res)
    );

    register_file_writeback u_regfile (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .rs1_addr_i     (decoded.rs1),
        .rs2_addr_i     (decoded.rs2),
        .exec_i         (exec_res),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_o       (result_o)
    );

endmodule

`default_nettype wire

/* test/clock_gen.sv */
// Testbench clock source with a 40 ns period, instantiated by the execution unit testbench.
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk_o
);
    localparam int HALF_PERIOD_NS = 20;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD_NS;
            clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

/* test/integer_exec_unit_properties.sv */
// Concurrent checks on the execution unit outputs, attached to the top level with bind.
`timescale 1ns/1ps
`default_nettype none

module integer_exec_unit_properties (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    instr_valid_i,
    input rv_isa_pkg::instr_word_t instr_i,
    input logic                    result_valid_i,
    input logic                    illegal_i
);
    import rv_isa_pkg::*;

    // legal encodings among op, op-imm and lui.
    function automatic logic encoding_is_legal(input instr_word_t ins);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = ins[14:12];
        f7 = ins[31:25];
        case (ins[6:0])
            OPC_OP:     return (f7 == F7_BASE)
                            || ((f7 == F7_ALT) && ((f3 == F3_ADD_SUB) || (f3 == F3_SR)));
            OPC_OP_IMM: return ((f3 != F3_SLL) && (f3 != F3_SR)) || (f7 == F7_BASE)
                            || ((f3 == F3_SR) && (f7 == F7_ALT));
            OPC_LUI:    return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

    // one sampled instruction gives a result or an illegal pulse.
    result_or_illegal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(result_valid_i && illegal_i))
        else $error("result_valid_o and illegal_o are high in the same cycle");

    no_result_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |=> !result_valid_i)
        else $error("result_valid_o is high in the cycle after reset release");

    // a second pulse needs another illegal instruction on the following edge.
    illegal_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        illegal_i |=> !illegal_i
            || ($past(instr_valid_i, 2) && !encoding_is_legal($past(instr_i, 2))))
        else $error("illegal_o stays high without a second illegal instruction");

endmodule

bind integer_exec_unit integer_exec_unit_properties props_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .result_valid_i (result_valid_o),
    .illegal_i      (illegal_o)
);

`default_nettype wire

/* test/integer_exec_unit_tb.sv */
// Testbench for the execution unit: seeded random RV32I instructions checked against a model.
`timescale 1ns/1ps
`default_nettype none

module integer_exec_unit_tb;
    import rv_isa_pkg::*;

    localparam int NUM_CYCLES    = 600;
    localparam int RESET_CYCLES  = 8;
    localparam int CLK_PERIOD_NS = 40;
    localparam int DRIVE_DELAY   = 2;

    typedef struct packed {
        logic        illegal;
        reg_addr_t   rd;
        xlen_word_t  value;
        logic [31:0] due_cycle;
    } expect_t;

    logic        clk_i;
    logic        rst_n_i;
    logic        instr_valid_i;
    instr_word_t instr_i;
    logic        result_valid_o;
    reg_addr_t   result_rd_o;
    xlen_word_t  result_o;
    logic        illegal_o;

    integer      seed;
    logic [31:0] cycle_cnt = '0;
    xlen_word_t  model_regs [NUM_REGS];
    expect_t     exp_q [$];

    clock_gen clk_gen_i (
        .clk_o (clk_i)
    );

    integer_exec_unit integer_exec_unit_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_o       (result_o),
        .illegal_o      (illegal_o)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // ########################################################################
    // reference model
    // ########################################################################

    function automatic xlen_word_t alu_ref(input logic [2:0] f3, input logic alt,
                                           input xlen_word_t a, input xlen_word_t b);
        logic [4:0] sh;
        xlen_word_t fill;
        sh   = b[4:0];
        // sign bits shifted in by an arithmetic right shift.
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? ((a >> sh) | fill) : (a >> sh);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_instr(input instr_word_t ins, output expect_t e);
        logic [6:0] f7;
        logic [2:0] f3;
        reg_addr_t  rd;
        xlen_word_t a;
        xlen_word_t val;
        logic       bad;
        f7  = ins[31:25];
        f3  = ins[14:12];
        rd  = ins[11:7];
        a   = model_regs[ins[19:15]];
        bad = 1'b0;
        val = '0;
        case (ins[6:0])
            OPC_OP: begin
                if (f7 == F7_ALT) begin
                    bad = !((f3 == 3'b000) || (f3 == 3'b101));
                end else begin
                    bad = (f7 != F7_BASE);
                end
                val = alu_ref(f3, f7 == F7_ALT, a, model_regs[ins[24:20]]);
            end
            OPC_OP_IMM: begin
                if (f3 == 3'b001) begin
                    bad = (f7 != F7_BASE);
                end else if (f3 == 3'b101) begin
                    bad = (f7 != F7_BASE) && (f7 != F7_ALT);
                end
                val = alu_ref(f3, (f3 == 3'b101) && (f7 == F7_ALT), a,
                              {{20{ins[31]}}, ins[31:20]});
            end
            OPC_LUI: val = {ins[31:12], 12'h000};
            default: bad = 1'b1;
        endcase
        if (!bad && (rd != 5'd0)) begin
            model_regs[rd] = val;
        end
        e.illegal   = bad;
        e.rd        = rd;
        e.value     = val;
        e.due_cycle = cycle_cnt + 2;
    endtask

    // ########################################################################
    // stimulus
    // ########################################################################

    // registers come from x0..x7 so that dependencies are frequent.
    task automatic make_instr(output instr_word_t ins);
        logic [31:0] r;
        logic [31:0] k;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r   = $random(seed);
        k   = $random(seed);
        rd  = {2'b00, r[2:0]};
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3  = r[11:9];
        f7  = (r[12] && ((f3 == F3_ADD_SUB) || (f3 == F3_SR))) ? F7_ALT : F7_BASE;
        case (k % 20)
            0, 1, 2, 3, 4, 5, 6: ins = {f7, rs2, rs1, f3, rd, OPC_OP};
            7, 8, 9, 10, 11, 12: begin
                if ((f3 == F3_SLL) || (f3 == F3_SR)) begin
                    ins = {f7, r[17:13], rs1, f3, rd, OPC_OP_IMM};
                end else begin
                    ins = {r[24:13], rs1, f3, rd, OPC_OP_IMM};
                end
            end
            13, 14, 15: ins = {r[31:12], rd, OPC_LUI};
            // mul encoding, not part of rv32i.
            16: ins = {7'b0000001, rs2, rs1, f3, rd, OPC_OP};
            17: ins = {F7_ALT, rs2, rs1, F3_XOR, rd, OPC_OP};
            18: ins = {F7_ALT, r[17:13], rs1, F3_SLL, rd, OPC_OP_IMM};
            default: ins = {r[31:12], rd, r[13] ? 7'b0000011 : 7'b1100011};
        endcase
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        instr_word_t ins;
        expect_t     e;
        r = $random(seed);
        make_instr(ins);
        instr_i = ins;
        if (r[1:0] == 2'b00) begin
            instr_valid_i = 1'b0;
        end else begin
            instr_valid_i = 1'b1;
            model_instr(ins, e);
            exp_q.push_back(e);
        end
    endtask

    // ########################################################################
    // checking
    // ########################################################################

    task automatic check_outputs();
        expect_t want;
        logic    due;
        due = (exp_q.size() != 0) && (exp_q[0].due_cycle == cycle_cnt);
        if (result_valid_o || illegal_o) begin
            assert (due) else begin
                report_failure($sformatf("unexpected output at %0t with no instruction due",
                                         $time));
            end
            want = exp_q.pop_front();
            assert (illegal_o == want.illegal) else begin
                report_failure($sformatf("Mismatch at %0t: illegal_o expected %0b actual %0b",
                                         $time, want.illegal, illegal_o));
            end
            assert (result_valid_o == !want.illegal) else begin
                report_failure($sformatf("Mismatch at %0t: result_valid_o expected %0b actual %0b",
                                         $time, !want.illegal, result_valid_o));
            end
            if (!want.illegal) begin
                assert (result_rd_o == want.rd) else begin
                    report_failure($sformatf("Mismatch at %0t: result_rd_o expected %0d actual %0d",
                                             $time, want.rd, result_rd_o));
                end
                assert (result_o == want.value) else begin
                    report_failure($sformatf("Mismatch at %0t: result_o expected %h actual %h",
                                             $time, want.value, result_o));
                end
            end
        end else begin
            assert (!due) else begin
                report_failure($sformatf("no result or illegal pulse at %0t, two edges after %s",
                                         $time, "the instruction was sampled"));
            end
        end
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // outputs are stable at the falling edge.
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            check_outputs();
        end
    end

    initial begin
        #((NUM_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD_NS);
        report_failure("watchdog timeout, the run did not finish in time");
    end

    initial begin
        seed          = 84434;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;
        repeat (NUM_CYCLES) begin
            drive_cycle();
            @(posedge clk_i);
            #DRIVE_DELAY;
        end
        instr_valid_i = 1'b0;
        // fixed two-edge latency, a few spare cycles drain the pipe.
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        if (exp_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_failure($sformatf("%0d expected results never appeared", exp_q.size()));
        end
    end

endmodule

`default_nettype wire

/* integer_exec_unit.f */
logic/rv_isa_pkg.sv
logic/exec_ctrl_pkg.sv
logic/instr_decoder.sv
logic/carry_lookahead_toplayici.sv
logic/aritmetik_mantik_birimi.sv
logic/register_file_writeback.sv
logic/integer_exec_unit.sv
test/clock_gen.sv
test/integer_exec_unit_properties.sv
test/integer_exec_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the execution unit testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f integer_exec_unit.f --top-module integer_exec_unit_tb \
    -o integer_exec_unit_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/integer_exec_unit_sim 2>&1)
run_status=$?
printf '%s\n' "$output"

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
